/* hw/fma_pkg.sv */
// Shared definitions for the floating-point multiply-accumulate cell
// Single-precision word layout, bias and the widths used inside the
// pipeline for products and accumulated sums

package fma_pkg;

    // --------------------------------------------------
    // IEEE single-precision format
    // --------------------------------------------------
    localparam int FLOAT_W  = 32;
    localparam int EXP_W    = 8;
    localparam int MAN_W    = 23;
    localparam int EXP_BIAS = 127;

    // --------------------------------------------------
    // Internal number widths
    // --------------------------------------------------

    // Product of two 24-bit mantissas, hidden ones included
    localparam int PROD_MAN_W = 2 * (MAN_W + 1);

    // Signed biased exponent, with headroom above and below the field
    localparam int ACC_EXP_W = 10;

    // Answer word given for a dot product that saw a bad input
    localparam logic [FLOAT_W-1:0] ERROR_WORD = '1;

    // --------------------------------------------------
    // Operand word
    // --------------------------------------------------
    typedef struct packed {
        logic             sign;
        logic [EXP_W-1:0] exp;   // Biased exponent
        logic [MAN_W-1:0] man;   // Stored fraction, hidden one dropped
    } float_fields_t;

    // Raw bits on the ports, fields for checking and arithmetic
    typedef union packed {
        logic [FLOAT_W-1:0] raw;
        float_fields_t      f;
    } float_word_u;

endpackage : fma_pkg

/* hw/fma_if.sv */
// Inter-stage links of the multiply-accumulate pipeline
// Both use valid/ready: a transfer happens when valid and ready are high
// together, and the payload holds while valid waits for ready

// --------------------------------------------------
// Operand pair, capture to multiply
// --------------------------------------------------
interface operand_pair_if;
    import fma_pkg::*;

    logic        valid;
    logic        ready;
    float_word_u a;
    float_word_u b;
    logic        last;   // DOT_LEN-th pair of a dot product
    logic        err;    // Denormal, infinity or NaN seen

    modport source (output valid, a, b, last, err, input ready);
    modport sink   (input valid, a, b, last, err, output ready);

endinterface : operand_pair_if

// --------------------------------------------------
// Product or finished sum
// --------------------------------------------------
interface product_if;
    import fma_pkg::*;

    logic                        valid;
    logic                        ready;
    logic                        sign;
    logic signed [ACC_EXP_W-1:0] exp;  // Biased, may leave the 8-bit range
    logic [PROD_MAN_W-1:0]       man;  // Hidden one at bit PROD_MAN_W-2
    logic                        last;
    logic                        err;

    modport source (output valid, sign, exp, man, last, err, input ready);
    modport sink   (input valid, sign, exp, man, last, err, output ready);

endinterface : product_if

/* hw/fma_operand_capture.sv */
// Operand capture stage
// Receiving side of the four-phase operand handshake. Registers each
// pair, checks both words for denormal, infinite and NaN values, and
// marks every DOT_LEN-th pair as the last of its dot product

module fma_operand_capture #(
    parameter int DOT_LEN = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_req,
    output logic                        in_ack,
    input  logic [fma_pkg::FLOAT_W-1:0] in_a,
    input  logic [fma_pkg::FLOAT_W-1:0] in_b,
    operand_pair_if.source              out
);
    import fma_pkg::*;

    localparam int CNT_W = $clog2(DOT_LEN + 1);

    float_word_u      a_w;
    float_word_u      b_w;
    logic             take;
    logic             last_pair;
    logic [CNT_W-1:0] count;   // Pairs taken so far in this dot product

    // All-ones exponent is inf/NaN, zero exponent with fraction is denormal
    function automatic logic is_bad(input float_word_u w);
        return (w.f.exp == '1) || ((w.f.exp == '0) && (w.f.man != '0));
    endfunction

    assign a_w.raw = in_a;
    assign b_w.raw = in_b;

    // New request, not yet acked, and room in the output register
    assign take      = in_req && !in_ack && (!out.valid || out.ready);
    assign last_pair = (count == CNT_W'(DOT_LEN - 1));

    // --------------------------------------------------
    // Handshake and pair counter
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            in_ack    <= 1'b0;
            out.valid <= 1'b0;
            count     <= '0;
        end else begin
            if (take) begin
                in_ack <= 1'b1;
            end else if (!in_req) begin
                in_ack <= 1'b0;   // Source has let go, close the cycle
            end

            if (take) begin
                out.valid <= 1'b1;
            end else if (out.ready) begin
                out.valid <= 1'b0;
            end

            if (take) begin
                count <= last_pair ? '0 : count + 1'b1;
            end
        end
    end

    // Pair payload
    always_ff @(posedge clk) begin
        if (take) begin
            out.a    <= a_w;
            out.b    <= b_w;
            out.last <= last_pair;
            out.err  <= is_bad(a_w) || is_bad(b_w);
        end
    end

    // Ack only ever answers a request seen on the cycle before
    a_ack_follows_req: assert property (
        @(posedge clk) disable iff (rst) $rose(in_ack) |-> $past(in_req)
    ) else $error("in_ack rose without a request");

endmodule : fma_operand_capture

/* hw/fma_multiply.sv */
// Multiply stage
// Forms sign, biased exponent and full 48-bit mantissa product of one
// operand pair in a single cycle. A zero operand gives a zero product

module fma_multiply (
    input  logic            clk,
    input  logic            rst,
    operand_pair_if.sink    in,
    product_if.source       out
);
    import fma_pkg::*;

    logic                        zero_op;
    logic                        take;
    logic signed [ACC_EXP_W-1:0] exp_sum;
    logic [PROD_MAN_W-1:0]       man_prod;

    assign in.ready = !out.valid || out.ready;
    assign take     = in.valid && in.ready;

    always_comb begin
        zero_op = ((in.a.f.exp == '0) && (in.a.f.man == '0)) ||
                  ((in.b.f.exp == '0) && (in.b.f.man == '0));

        // Both exponents carry the bias, so remove one copy
        exp_sum = ACC_EXP_W'(in.a.f.exp) + ACC_EXP_W'(in.b.f.exp)
                  - ACC_EXP_W'(EXP_BIAS);

        man_prod = {1'b1, in.a.f.man} * {1'b1, in.b.f.man};  // Hidden ones back
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else if (take) begin
            out.valid <= 1'b1;
        end else if (out.ready) begin
            out.valid <= 1'b0;
        end
    end

    // Product payload
    always_ff @(posedge clk) begin
        if (take) begin
            out.sign <= in.a.f.sign ^ in.b.f.sign;
            out.last <= in.last;
            out.err  <= in.err;
            if (zero_op) begin
                out.exp <= '0;
                out.man <= '0;
            end else begin
                out.exp <= exp_sum;
                out.man <= man_prod;
            end
        end
    end

endmodule : fma_multiply

/* hw/fma_accumulate.sv */
// Accumulate stage
// Aligns each product to the running sum by exponent difference, adds
// or subtracts the magnitudes and renormalizes a carry. The sum and a
// sticky error flag are released on the last pair, then cleared

module fma_accumulate (
    input  logic          clk,
    input  logic          rst,
    product_if.sink       in,
    product_if.source     out
);
    import fma_pkg::*;

    logic                        take;

    // Running sum
    logic                        acc_sign;
    logic signed [ACC_EXP_W-1:0] acc_exp;
    logic [PROD_MAN_W-1:0]       acc_man;
    logic                        acc_err;

    // Product reduced to a single leading one
    logic signed [ACC_EXP_W-1:0] p_exp;
    logic [PROD_MAN_W-1:0]       p_man;

    logic                        prod_big;
    logic [ACC_EXP_W-1:0]        shift;
    logic                        big_sign;
    logic                        small_sign;
    logic signed [ACC_EXP_W-1:0] big_exp;
    logic [PROD_MAN_W-1:0]       big_man;
    logic [PROD_MAN_W-1:0]       aligned;
    logic [PROD_MAN_W-1:0]       raw_sum;
    logic                        nxt_sign;
    logic signed [ACC_EXP_W-1:0] nxt_exp;
    logic [PROD_MAN_W-1:0]       nxt_man;

    assign in.ready = !out.valid || out.ready;
    assign take     = in.valid && in.ready;

    // --------------------------------------------------
    // Align, add or subtract, normalize
    // --------------------------------------------------
    always_comb begin
        if (in.man[PROD_MAN_W-1]) begin   // Mantissa product reached 2.0
            p_man = in.man >> 1;
            p_exp = in.exp + 1;
        end else begin
            p_man = in.man;
            p_exp = in.exp;
        end

        // A zero side never sets the exponent
        prod_big = (acc_man == '0) || ((p_man != '0) && (p_exp > acc_exp));

        if (prod_big) begin
            shift      = p_exp - acc_exp;
            big_sign   = in.sign;
            big_exp    = p_exp;
            big_man    = p_man;
            small_sign = acc_sign;
            aligned    = acc_man >> shift;   // Shifted-out bits truncate
        end else begin
            shift      = acc_exp - p_exp;
            big_sign   = acc_sign;
            big_exp    = acc_exp;
            big_man    = acc_man;
            small_sign = in.sign;
            aligned    = p_man >> shift;
        end

        if (big_sign == small_sign) begin
            raw_sum  = big_man + aligned;
            nxt_sign = big_sign;
        end else if (big_man >= aligned) begin
            raw_sum  = big_man - aligned;
            nxt_sign = big_sign;
        end else begin
            raw_sum  = aligned - big_man;   // Equal exponents, smaller side wins
            nxt_sign = small_sign;
        end

        if (raw_sum[PROD_MAN_W-1]) begin
            nxt_man = raw_sum >> 1;
            nxt_exp = big_exp + 1;
        end else begin
            nxt_man = raw_sum;
            nxt_exp = big_exp;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_sign  <= 1'b0;
            acc_exp   <= '0;
            acc_man   <= '0;
            acc_err   <= 1'b0;
            out.valid <= 1'b0;
        end else begin
            if (take && in.last) begin
                acc_sign  <= 1'b0;
                acc_exp   <= '0;
                acc_man   <= '0;
                acc_err   <= 1'b0;
                out.valid <= 1'b1;
            end else begin
                if (take) begin
                    acc_sign <= nxt_sign;
                    acc_exp  <= nxt_exp;
                    acc_man  <= nxt_man;
                    acc_err  <= acc_err | in.err;
                end
                if (out.ready) out.valid <= 1'b0;
            end
        end
    end

    // Finished sum
    always_ff @(posedge clk) begin
        if (take && in.last) begin
            out.sign <= nxt_sign;
            out.exp  <= nxt_exp;
            out.man  <= nxt_man;
            out.last <= in.last;
            out.err  <= acc_err | in.err;
        end
    end

    a_out_on_last: assert property (
        @(posedge clk) disable iff (rst) $rose(out.valid) |-> $past(in.valid && in.last)
    ) else $error("Sum released before the last pair");

endmodule : fma_accumulate

/* hw/fma_answer_port.sv */
// Answer port
// Left-normalizes a finished sum, packs it into a single-precision word
// and presents it on the four-phase answer handshake. An errored sum is
// given as the all-ones word with ans_error high

module fma_answer_port (
    input  logic                         clk,
    input  logic                         rst,
    product_if.sink                      in,
    output logic                         ans_req,
    input  logic                         ans_ack,
    output logic [fma_pkg::FLOAT_W-1:0]  ans_data,
    output logic                         ans_error
);
    import fma_pkg::*;

    localparam int HIDDEN = PROD_MAN_W - 2;
    localparam int LEAD_W = $clog2(PROD_MAN_W);

    localparam logic [1:0] S_IDLE = 2'd0;   // Ready for a sum
    localparam logic [1:0] S_PACK = 2'd1;
    localparam logic [1:0] S_REQ  = 2'd2;   // Waiting for ans_ack
    localparam logic [1:0] S_DROP = 2'd3;   // Waiting for ans_ack to fall

    logic [1:0]                  state;
    logic                        sum_sign;
    logic signed [ACC_EXP_W-1:0] sum_exp;
    logic [PROD_MAN_W-1:0]       sum_man;
    logic                        sum_err;
    logic [LEAD_W-1:0]           lead;
    logic [LEAD_W-1:0]           shift_amt;
    logic [PROD_MAN_W-1:0]       norm_man;
    logic signed [ACC_EXP_W-1:0] norm_exp;
    float_word_u                 word;

    assign in.ready = (state == S_IDLE);

    // --------------------------------------------------
    // Normalize and pack
    // --------------------------------------------------
    always_comb begin
        lead = '0;
        for (int i = 0; i <= HIDDEN; i++) begin
            if (sum_man[i]) lead = LEAD_W'(i);
        end
        shift_amt = LEAD_W'(HIDDEN) - lead;
        norm_man  = sum_man << shift_amt;
        norm_exp  = sum_exp - ACC_EXP_W'(shift_amt);

        word.f.sign = sum_sign;
        word.f.exp  = norm_exp[EXP_W-1:0];
        word.f.man  = norm_man[HIDDEN-1 -: MAN_W];   // Low bits truncate
        if (sum_err) begin
            word.raw = ERROR_WORD;
        end else if (sum_man == '0) begin
            word.raw = '0;   // Cancelled sum, positive zero
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            ans_req   <= 1'b0;
            ans_error <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (in.valid) state <= S_PACK;
                S_PACK: begin
                    ans_req   <= 1'b1;
                    ans_error <= sum_err;
                    state     <= S_REQ;
                end
                S_REQ: begin
                    if (ans_ack) begin
                        ans_req <= 1'b0;
                        state   <= S_DROP;
                    end
                end
                default: if (!ans_ack) state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.ready) begin
            sum_sign <= in.sign;
            sum_exp  <= in.exp;
            sum_man  <= in.man;
            sum_err  <= in.err;
        end
        if (state == S_PACK) ans_data <= word.raw;
    end

    a_data_stable: assert property (
        @(posedge clk) disable iff (rst)
        ($past(ans_req) && !$past(ans_ack) && ans_req) |-> $stable(ans_data) && $stable(ans_error)
    ) else $error("Answer changed during the handshake");

endmodule : fma_answer_port

/* hw/fma_cell.sv */
// Floating-point multiply-accumulate cell
// Takes single-precision operand pairs over a four-phase handshake,
// sums DOT_LEN products, and returns each dot product over a second
// four-phase handshake. Four pipelined stages, several items in flight

module fma_cell #(
    parameter int DOT_LEN = 4
) (
    input  logic                        clk,
    input  logic                        rst,

    // Operand port
    input  logic                        in_req,
    output logic                        in_ack,
    input  logic [fma_pkg::FLOAT_W-1:0] in_a,
    input  logic [fma_pkg::FLOAT_W-1:0] in_b,

    // Answer port
    output logic                        ans_req,
    input  logic                        ans_ack,
    output logic [fma_pkg::FLOAT_W-1:0] ans_data,
    output logic                        ans_error
);

    operand_pair_if pair_if ();
    product_if      prod_if ();
    product_if      sum_if ();   // Finished dot products only

    fma_operand_capture #(
        .DOT_LEN (DOT_LEN)
    ) i_capture (
        .clk    (clk),
        .rst    (rst),
        .in_req (in_req),
        .in_ack (in_ack),
        .in_a   (in_a),
        .in_b   (in_b),
        .out    (pair_if.source)
    );

    fma_multiply i_multiply (
        .clk (clk),
        .rst (rst),
        .in  (pair_if.sink),
        .out (prod_if.source)
    );

    fma_accumulate i_accumulate (
        .clk (clk),
        .rst (rst),
        .in  (prod_if.sink),
        .out (sum_if.source)
    );

    fma_answer_port i_answer (
        .clk       (clk),
        .rst       (rst),
        .in        (sum_if.sink),
        .ans_req   (ans_req),
        .ans_ack   (ans_ack),
        .ans_data  (ans_data),
        .ans_error (ans_error)
    );

endmodule : fma_cell

/* include/fma_cell_tests.svh */
// Directed tests for the multiply-accumulate cell testbench
// Each task drives whole dot products and checks the answers against
// exact integer results

`ifndef FMA_CELL_TESTS_SVH
`define FMA_CELL_TESTS_SVH

task automatic set_pairs(input int a0, b0, a1, b1, a2, b2, a3, b3);
    dot_a[0] = a0;
    dot_b[0] = b0;
    dot_a[1] = a1;
    dot_b[1] = b1;
    dot_a[2] = a2;
    dot_b[2] = b2;
    dot_a[3] = a3;
    dot_b[3] = b3;
endtask

task automatic check_reset_state();
    check(32'(in_ack), 32'd0, "in_ack after reset");
    check(32'(ans_req), 32'd0, "ans_req after reset");
    check(32'(ans_error), 32'd0, "ans_error after reset");
endtask

task automatic positive_dots();
    int sum;
    set_pairs(3, 5, 7, 2, 10, 10, 12, 9);
    send_dot(sum);
    expect_answer(to_float(sum), 1'b0, "small positive dot");
    set_pairs(100, 200, 300, 40, 1000, 1000, 25, 4);   // Wide exponent spread
    send_dot(sum);
    expect_answer(to_float(sum), 1'b0, "wide positive dot");
endtask

task automatic mixed_sign_dots();
    int sum;
    set_pairs(3, 4, -2, 6, 5, 0, 0, 7);   // Cancels to zero
    send_dot(sum);
    expect_answer(to_float(sum), 1'b0, "cancelled dot");
    set_pairs(-7, 9, 3, -5, 2, 4, -1, 1);
    send_dot(sum);
    expect_answer(to_float(sum), 1'b0, "negative dot");
    set_pairs(1000, 1000, -999, 1001, 0, 5, 3, 0);   // Leaves a single one
    send_dot(sum);
    expect_answer(to_float(sum), 1'b0, "near cancellation dot");
endtask

// One bad word in operand a of the given slot, clean pairs elsewhere
task automatic send_with_bad_operand(input logic [31:0] bad, input int slot);
    for (int i = 0; i < DOT_LEN; i++) begin
        if (i == slot) send_pair(bad, to_float(i + 2));
        else send_pair(to_float(i + 1), to_float(3));
    end
endtask

task automatic bad_input_dots();
    int sum;
    send_with_bad_operand(32'h7FC0_0000, 1);   // Quiet NaN
    expect_answer(ERR_ANSWER, 1'b1, "NaN dot");
    send_with_bad_operand(32'hFF80_0000, 3);   // Negative infinity on the last pair
    expect_answer(ERR_ANSWER, 1'b1, "infinity dot");
    send_with_bad_operand(32'h0000_0001, 0);   // Smallest denormal
    expect_answer(ERR_ANSWER, 1'b1, "denormal dot");
    set_pairs(1, 2, 3, 4, 5, 6, 7, 8);
    send_dot(sum);
    expect_answer(to_float(sum), 1'b0, "clean dot after errors");
endtask

// --------------------------------------------------
// Held answer port while more pairs arrive
// --------------------------------------------------
task automatic back_pressure();
    int pa[3][DOT_LEN];
    int pb[3][DOT_LEN];
    int sums[3];
    int unused_sum;
    max_ack_wait = 0;
    for (int d = 0; d < 3; d++) begin
        sums[d] = 0;
        for (int i = 0; i < DOT_LEN; i++) begin
            pa[d][i] = 4 * d + i + 1;
            pb[d][i] = 2 * i - 3 + d;
            sums[d] += pa[d][i] * pb[d][i];
        end
    end
    fork
        begin
            for (int d = 0; d < 3; d++) begin
                dot_a = pa[d];
                dot_b = pb[d];
                send_dot(unused_sum);
            end
        end
        begin
            while (!ans_req) next_cycle();
            repeat (30) next_cycle();   // Withhold ans_ack
            for (int d = 0; d < 3; d++) begin
                expect_answer(to_float(sums[d]), 1'b0, $sformatf("held dot %0d", d));
            end
        end
    join
    check(32'(max_ack_wait >= 10), 32'd1, "in_ack stall under back-pressure");
endtask

task automatic random_dots();
    int sum;
    for (int n = 0; n < 20; n++) begin
        for (int i = 0; i < DOT_LEN; i++) begin
            dot_a[i] = int'($urandom_range(100, 0)) - 50;
            dot_b[i] = int'($urandom_range(100, 0)) - 50;
        end
        send_dot(sum);
        expect_answer(to_float(sum), 1'b0, $sformatf("random dot %0d", n));
    end
endtask

`endif

/* verif/fma_cell_tb.sv */
// Testbench for the floating-point multiply-accumulate cell
// Sends operand pairs over the four-phase operand port, collects dot
// products from the answer port and compares them with integer sums

module fma_cell_tb;

    localparam int DOT_LEN        = 4;
    localparam int ANS_WAIT_MAX   = 40;    // Cycles allowed for an answer to show up
    localparam int MAX_DOTS       = 40;
    localparam int CYCLES_PER_DOT = 60;
    localparam int TIMEOUT_CYCLES = MAX_DOTS * CYCLES_PER_DOT + 600;
    localparam logic [31:0] ERR_ANSWER = 32'hFFFF_FFFF;

    logic        clk;
    logic        rst;
    logic        in_req;
    logic        in_ack;
    logic [31:0] in_a;
    logic [31:0] in_b;
    logic        ans_req;
    logic        ans_ack;
    logic [31:0] ans_data;
    logic        ans_error;

    int          cycles;
    int          max_ack_wait;   // Longest in_ack wait seen by send_pair
    int          dot_a[DOT_LEN];
    int          dot_b[DOT_LEN];

    fma_cell #(
        .DOT_LEN (DOT_LEN)
    ) i_fma_cell (
        .clk       (clk),
        .rst       (rst),
        .in_req    (in_req),
        .in_ack    (in_ack),
        .in_a      (in_a),
        .in_b      (in_b),
        .ans_req   (ans_req),
        .ans_ack   (ans_ack),
        .ans_data  (ans_data),
        .ans_error (ans_error)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // --------------------------------------------------
    // Failure reporting and checks
    // --------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] expected,
                         input string what);
        if (got !== expected) begin
            abort_run($sformatf("MISMATCH at %0t: %s, got %h, expected %h",
                                $time, what, got, expected));
        end
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // --------------------------------------------------
    // Handshake drivers
    // --------------------------------------------------

    // Drive and sample point, just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_pair(input logic [31:0] a, input logic [31:0] b);
        int waited;
        waited = 0;
        in_a   = a;
        in_b   = b;
        in_req = 1'b1;
        next_cycle();
        while (!in_ack) begin
            waited++;
            next_cycle();
        end
        if (waited > max_ack_wait) max_ack_wait = waited;
        in_req = 1'b0;
        next_cycle();
        while (in_ack) next_cycle();   // Cell closes the cycle
    endtask

    task automatic take_answer(output logic [31:0] data, output logic err);
        int waited;
        waited = 0;
        while (!ans_req) begin
            if (waited >= ANS_WAIT_MAX) begin
                abort_run($sformatf("No answer arrived within %0d cycles", ANS_WAIT_MAX));
            end
            waited++;
            next_cycle();
        end
        data    = ans_data;
        err     = ans_error;
        ans_ack = 1'b1;
        next_cycle();
        while (ans_req) next_cycle();
        ans_ack = 1'b0;
        next_cycle();
    endtask

    // Exact single-precision word of an integer below 2^24 in magnitude
    function automatic logic [31:0] to_float(input int v);
        logic [31:0] mag;
        logic [31:0] word;
        int          msb;
        if (v == 0) return 32'h0;
        mag = (v < 0) ? -v : v;
        msb = 0;
        for (int i = 0; i < 32; i++) begin
            if (mag[i]) msb = i;
        end
        word[31]    = (v < 0);
        word[30:23] = 8'(127 + msb);
        word[22:0]  = 23'(mag << (23 - msb));   // Leading one drops out
        return word;
    endfunction

    // Sends dot_a/dot_b as one dot product, returns the integer result
    task automatic send_dot(output int sum);
        sum = 0;
        for (int i = 0; i < DOT_LEN; i++) begin
            send_pair(to_float(dot_a[i]), to_float(dot_b[i]));
            sum += dot_a[i] * dot_b[i];
        end
    endtask

    task automatic expect_answer(input logic [31:0] exp_data, input logic exp_err,
                                 input string what);
        logic [31:0] data;
        logic        err;
        take_answer(data, err);
        check(data, exp_data, {what, " data"});
        check(32'(err), 32'(exp_err), {what, " error flag"});
    endtask

    `include "fma_cell_tests.svh"

    // --------------------------------------------------
    // Run order
    // --------------------------------------------------
    initial begin
        void'($urandom(76734));
        max_ack_wait = 0;
        rst          = 1'b1;
        in_req       = 1'b0;
        in_a         = '0;
        in_b         = '0;
        ans_ack      = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        check_reset_state();
        positive_dots();
        mixed_sign_dots();
        bad_input_dots();
        back_pressure();
        random_dots();

        $display("** PASS **");
        $finish;
    end

endmodule : fma_cell_tb

/* fma_cell.f */
+incdir+include
hw/fma_pkg.sv
hw/fma_if.sv
hw/fma_operand_capture.sv
hw/fma_multiply.sv
hw/fma_accumulate.sv
hw/fma_answer_port.sv
hw/fma_cell.sv
verif/fma_cell_tb.sv

/* Makefile */
# Verilator build and run of the fma_cell testbench

VERILATOR ?= verilator
TOP       ?= fma_cell_tb
FLIST     ?= fma_cell.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(FLIST) $(wildcard hw/*.sv) $(wildcard verif/*.sv) $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
